/* flist.f */
verilog/soc_pkg.sv
verilog/soc_ram.sv
verilog/mem_bus.sv
verilog/serial_shifter.sv
verilog/ledmtx_driver.sv
verilog/spi_flash_reader.sv
verilog/io_regs.sv
verilog/soc_top.sv
sim/soc_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= soc_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary -j 0 -Wno-fatal

SRCS := $(shell cat $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

/* sim/soc_tb.sv */
// testbench for the soc memory and peripheral side
// drives the processor bus like a cpu, models the spi flash and captures the led matrix frames
module soc_tb;
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum int {op_write, op_read, op_burst, op_leds, op_buttons, op_ledmtx, op_flash} op_e;

  // one stimulus row, exp is used by the io reads only
  typedef struct {
    string       name;
    op_e         op;
    logic [23:0] addr;
    logic [31:0] data;
    logic [3:0]  mask;
    logic [31:0] exp;
    logic [7:0]  fbyte;
  } entry_t;

  logic        clk;
  logic        RESET;
  logic [23:0] addr;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        rd;
  logic [31:0] rdata;
  logic        rvalid;
  logic [3:0]  leds;
  logic [5:0]  buttons;
  logic        ledmtx_din;
  logic        ledmtx_cs;
  logic        ledmtx_clk;
  logic        spi_mosi;
  logic        spi_miso;
  logic        spi_cs_n;
  logic        spi_clk;

  entry_t      stim[$];
  logic [31:0] ram_model [1024];
  int          seed = 18;
  int          errors = 0;
  int          cycles = 0;
  int          cycle_limit = 1000;
  // led matrix capture
  logic [15:0] mtx_bits;
  int          mtx_count;
  // flash model state
  logic [31:0] spi_cmd;
  int          spi_count = 0;
  logic [7:0]  flash_byte_cur;

  soc_top uut (
    .clk(clk), .RESET(RESET), .addr(addr), .wdata(wdata), .wstrb(wstrb), .rd(rd),
    .rdata(rdata), .rvalid(rvalid), .leds(leds), .buttons(buttons),
    .ledmtx_din(ledmtx_din), .ledmtx_cs(ledmtx_cs), .ledmtx_clk(ledmtx_clk),
    .spi_mosi(spi_mosi), .spi_miso(spi_miso), .spi_cs_n(spi_cs_n), .spi_clk(spi_clk)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // frame bits, sclk is high for a whole clock so the falling edge sees stable din
  always @(negedge clk) begin
    if (ledmtx_clk && !ledmtx_cs) begin
      mtx_bits = {mtx_bits[14:0], ledmtx_din};
      mtx_count++;
    end
  end

  // flash model, 32 command bits in, then the data byte out msb first
  // miso is set in the high phase and sampled by the dut at its end
  always @(negedge clk) begin
    if (spi_cs_n) begin
      spi_count = 0;
    end else if (spi_clk) begin
      if (spi_count < 32) begin
        spi_cmd = {spi_cmd[30:0], spi_mosi};
      end else if (spi_count < 40) begin
        spi_miso = flash_byte_cur[39 - spi_count];
      end
      spi_count++;
    end
  end

  // watchdog
  initial begin
    while (cycles <= cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, the tests did not finish", cycles);
    $display("Verification failed");
    $finish;
  end

  function automatic void add_entry(string name, op_e op, logic [23:0] a, logic [31:0] d,
                                    logic [3:0] m, logic [31:0] exp, logic [7:0] fbyte);
    entry_t e;
    e = '{name, op, a, d, m, exp, fbyte};
    stim.push_back(e);
  endfunction

  task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAIL %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  // called at a falling edge, returns at the falling edge after the strobe
  task automatic bus_write(input logic [23:0] a, input logic [31:0] d, input logic [3:0] m);
    addr  = a;
    wdata = d;
    wstrb = m;
    @(negedge clk);
    wstrb = '0;
    // ram page only, io writes must leave the ram alone
    if (!a[22]) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (m[lane]) begin
          ram_model[a[11:2]][lane*8 +: 8] = d[lane*8 +: 8];
        end
      end
    end
  endtask

  task automatic bus_read(input string name, input logic [23:0] a, output logic [31:0] d);
    addr = a;
    rd   = 1'b1;
    @(negedge clk);
    rd = 1'b0;
    d  = rdata;
    if (rvalid !== 1'b1) begin
      $display("read in %s got no rvalid one cycle after rd", name);
      errors++;
    end
  endtask

  task automatic apply_entry(input entry_t e);
    logic [31:0] d;
    int          polls;
    case (e.op)
      op_write: bus_write(e.addr, e.data, e.mask);
      op_read: begin
        bus_read(e.name, e.addr, d);
        compare_word(e.name, e.addr[22] ? e.exp : ram_model[e.addr[11:2]], d);
        // a single strobe gives a single pulse
        @(negedge clk);
        if (rvalid !== 1'b0) begin
          $display("rvalid in %s stayed high after a single read", e.name);
          errors++;
        end
      end
      op_burst: begin
        // one rd per cycle, each rvalid carries the word strobed just before
        for (int i = 0; i <= 4; i++) begin
          if (i > 0) begin
            if (rvalid !== 1'b1) begin
              $display("burst read %0d in %s got no rvalid", i - 1, e.name);
              errors++;
            end
            compare_word(e.name, ram_model[e.addr[11:2] + i - 1], rdata);
          end
          if (i < 4) begin
            addr = e.addr + 24'(4 * i);
            rd   = 1'b1;
            @(negedge clk);
          end else begin
            rd = 1'b0;
          end
        end
      end
      op_leds: begin
        bus_write(e.addr, e.data, e.mask);
        compare_word({e.name, "_pins"}, e.exp, 32'(leds));
        bus_read(e.name, e.addr, d);
        compare_word({e.name, "_readback"}, e.exp, d);
      end
      op_buttons: begin
        buttons = e.data[5:0];
        bus_read(e.name, e.addr, d);
        compare_word(e.name, e.exp, d);
      end
      op_ledmtx: begin
        mtx_count = 0;
        bus_write(e.addr, e.data, e.mask);
        bus_read(e.name, 24'h400100, d);
        compare_word({e.name, "_busy"}, 32'd1, d);
        while (ledmtx_cs !== 1'b1) begin
          @(negedge clk);
        end
        bus_read(e.name, 24'h400100, d);
        compare_word({e.name, "_idle"}, 32'd0, d);
        compare_word({e.name, "_bits"}, e.exp, 32'(mtx_bits));
        compare_word({e.name, "_count"}, 32'd16, 32'(mtx_count));
      end
      op_flash: begin
        flash_byte_cur = e.fbyte;
        bus_write(e.addr, e.data, e.mask);
        polls = 0;
        // poll until the busy bit drops
        do begin
          bus_read(e.name, e.addr, d);
          polls++;
        end while (d[8] === 1'b1 && polls < 100);
        if (d[8] !== 1'b0) begin
          $display("flash busy bit in %s never cleared", e.name);
          errors++;
        end
        compare_word({e.name, "_byte"}, 32'(e.fbyte), 32'(d[7:0]));
        compare_word({e.name, "_cmd"}, {8'h03, e.data[23:0]}, spi_cmd);
        repeat (2) @(negedge clk);
        if (spi_cs_n !== 1'b1) begin
          $display("spi_cs_n still low after %s finished", e.name);
          errors++;
        end
      end
      default: begin
        $display("unknown operation in %s", e.name);
        errors++;
      end
    endcase
  endtask

  initial begin
    logic [31:0] r;
    RESET    = 1'b0;
    addr     = '0;
    wdata    = '0;
    wstrb    = '0;
    rd       = 1'b0;
    buttons  = '0;
    spi_miso = 1'b0;

    // byte masking on one word, then a burst over four words
    add_entry("ram_full_write", op_write, 24'h000040, $random(seed), 4'hf, 0, 0);
    add_entry("ram_mask_low", op_write, 24'h000040, $random(seed), 4'b0011, 0, 0);
    add_entry("ram_mask_lane2", op_write, 24'h000040, $random(seed), 4'b0100, 0, 0);
    add_entry("ram_masked_read", op_read, 24'h000040, 0, 0, 0, 0);
    add_entry("ram_word_44", op_write, 24'h000044, $random(seed), 4'hf, 0, 0);
    add_entry("ram_word_48", op_write, 24'h000048, $random(seed), 4'hf, 0, 0);
    add_entry("ram_word_4c", op_write, 24'h00004c, $random(seed), 4'hf, 0, 0);
    add_entry("ram_mask_lane3", op_write, 24'h00004c, $random(seed), 4'b1000, 0, 0);
    add_entry("ram_back_to_back", op_burst, 24'h000040, 0, 0, 0, 0);
    // word 1 shares its offset with the led register
    add_entry("ram_word_1", op_write, 24'h000004, $random(seed), 4'hf, 0, 0);
    add_entry("led_register", op_leds, 24'h400004, 32'hfffffff5, 4'hf, 32'h5, 0);
    add_entry("ram_after_io_write", op_read, 24'h000004, 0, 0, 0, 0);
    add_entry("button_port", op_buttons, 24'h401000, 32'h2b, 0, 32'h2b, 0);
    r = $random(seed);
    add_entry("ledmtx_send_a", op_ledmtx, 24'h400200, r, 4'hf, {16'h0, r[15:0]}, 0);
    add_entry("ledmtx_send_b", op_ledmtx, 24'h400200, 32'h0000a381, 4'hf, 32'ha381, 0);
    add_entry("flash_read_a", op_flash, 24'h400400, 32'h00123456, 4'hf, 0, 8'ha5);
    r = $random(seed);
    add_entry("flash_read_b", op_flash, 24'h400400, r, 4'hf, 0, r[31:24]);
    cycle_limit = stim.size() * 200 + 100;

    repeat (10) @(negedge clk);
    RESET = 1'b1;
    @(negedge clk);
    // rvalid, leds, matrix cs clk din, flash cs_n clk mosi
    compare_word("reset_state", {21'h0, 1'b0, 4'h0, 3'b100, 3'b100},
                 {21'h0, rvalid, leds, ledmtx_cs, ledmtx_clk, ledmtx_din,
                  spi_cs_n, spi_clk, spi_mosi});

    foreach (stim[i]) begin
      apply_entry(stim[i]);
    end

    $display("checks done, %0d entries, %0d errors", stim.size(), errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* verilog/soc_top.sv */
// soc memory and peripheral side, processor bus exposed as ports
module soc_top (
  input  logic                          clk,
  input  logic                          RESET,
  // processor memory bus
  input  logic [soc_pkg::addr_w-1:0]    addr,
  input  logic [soc_pkg::data_w-1:0]    wdata,
  input  logic [soc_pkg::strb_w-1:0]    wstrb,
  input  logic                          rd,
  output logic [soc_pkg::data_w-1:0]    rdata,
  output logic                          rvalid,
  // board io
  output logic [soc_pkg::n_leds-1:0]    leds,
  input  logic [soc_pkg::n_buttons-1:0] buttons,
  // max7219 led matrix
  output logic                          ledmtx_din,
  output logic                          ledmtx_cs,
  output logic                          ledmtx_clk,
  // spi flash
  output logic                          spi_mosi,
  input  logic                          spi_miso,
  output logic                          spi_cs_n,
  output logic                          spi_clk
);

  // ram port
  logic [soc_pkg::ram_aw-1:0] ram_addr;
  logic [soc_pkg::data_w-1:0] ram_wdata;
  logic [soc_pkg::strb_w-1:0] ram_wstrb;
  logic                       ram_rd;
  logic [soc_pkg::data_w-1:0] ram_rdata;
  // io port
  logic [soc_pkg::io_aw-1:0]  io_addr;
  logic [soc_pkg::data_w-1:0] io_wdata;
  logic                       io_wr;
  logic [soc_pkg::data_w-1:0] io_rdata;

  mem_bus u_bus (
    .clk       (clk),
    .RESET     (RESET),
    .addr      (addr),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .rd        (rd),
    .rdata     (rdata),
    .rvalid    (rvalid),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_wstrb (ram_wstrb),
    .ram_rd    (ram_rd),
    .ram_rdata (ram_rdata),
    .io_addr   (io_addr),
    .io_wdata  (io_wdata),
    .io_wr     (io_wr),
    .io_rdata  (io_rdata)
  );

  soc_ram u_ram (
    .clk       (clk),
    .ram_addr  (ram_addr),
    .ram_wdata (ram_wdata),
    .ram_wstrb (ram_wstrb),
    .ram_rd    (ram_rd),
    .ram_rdata (ram_rdata)
  );

  io_regs u_io (
    .clk        (clk),
    .RESET      (RESET),
    .io_addr    (io_addr),
    .io_wdata   (io_wdata),
    .io_wr      (io_wr),
    .io_rdata   (io_rdata),
    .leds       (leds),
    .buttons    (buttons),
    .ledmtx_din (ledmtx_din),
    .ledmtx_cs  (ledmtx_cs),
    .ledmtx_clk (ledmtx_clk),
    .spi_mosi   (spi_mosi),
    .spi_miso   (spi_miso),
    .spi_cs_n   (spi_cs_n),
    .spi_clk    (spi_clk)
  );

endmodule

/* verilog/io_regs.sv */
// io page registers with one-hot word decode
// leds, buttons, led matrix sender and spi flash reader
module io_regs (
  input  logic                          clk,
  input  logic                          RESET,
  // bus side, strobes valid in the access cycle
  input  logic [soc_pkg::io_aw-1:0]     io_addr,
  input  logic [soc_pkg::data_w-1:0]    io_wdata,
  input  logic                          io_wr,
  output logic [soc_pkg::data_w-1:0]    io_rdata,
  // board pins
  output logic [soc_pkg::n_leds-1:0]    leds,
  input  logic [soc_pkg::n_buttons-1:0] buttons,
  output logic                          ledmtx_din,
  output logic                          ledmtx_cs,
  output logic                          ledmtx_clk,
  output logic                          spi_mosi,
  input  logic                          spi_miso,
  output logic                          spi_cs_n,
  output logic                          spi_clk
);

  logic       ledmtx_load;
  logic       ledmtx_busy;
  logic       flash_load;
  logic       flash_busy;
  logic [7:0] flash_byte;

  // led register
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      leds <= '0;
    end else if (io_wr && io_addr[soc_pkg::leds_bit]) begin
      leds <= io_wdata[soc_pkg::n_leds-1:0];
    end
  end

  // write strobes that start a transfer
  assign ledmtx_load = io_wr && io_addr[soc_pkg::ledmtx_dat_bit];
  assign flash_load  = io_wr && io_addr[soc_pkg::flash_bit];

  ledmtx_driver u_ledmtx (
    .clk   (clk),
    .RESET (RESET),
    .load  (ledmtx_load),
    .data  (soc_pkg::ledmtx_word_t'(io_wdata[15:0])),
    .busy  (ledmtx_busy),
    .din   (ledmtx_din),
    .cs    (ledmtx_cs),
    .sclk  (ledmtx_clk)
  );

  spi_flash_reader u_flash (
    .clk        (clk),
    .RESET      (RESET),
    .load       (flash_load),
    .flash_addr (io_wdata[23:0]),
    .busy       (flash_busy),
    .rx_byte    (flash_byte),
    .mosi       (spi_mosi),
    .miso       (spi_miso),
    .cs_n       (spi_cs_n),
    .sclk       (spi_clk)
  );

  // read-back, every selected register is ORed in
  // reads have no side effects
  always_comb begin
    io_rdata = '0;
    if (io_addr[soc_pkg::leds_bit]) begin
      io_rdata[soc_pkg::n_leds-1:0] = io_rdata[soc_pkg::n_leds-1:0] | leds;
    end
    if (io_addr[soc_pkg::ledmtx_cntl_bit]) begin
      io_rdata[0] = io_rdata[0] | ledmtx_busy;
    end
    // flash data byte with busy in bit 8
    if (io_addr[soc_pkg::flash_bit]) begin
      io_rdata[8:0] = io_rdata[8:0] | {flash_busy, flash_byte};
    end
    if (io_addr[soc_pkg::buttons_bit]) begin
      io_rdata[soc_pkg::n_buttons-1:0] = io_rdata[soc_pkg::n_buttons-1:0] | buttons;
    end
  end

endmodule

/* verilog/spi_flash_reader.sv */
// spi flash single-byte reader
// sends opcode 03 and a 24-bit address, then shifts in one data byte
module spi_flash_reader (
  input  logic        clk,
  input  logic        RESET,
  input  logic        load,
  input  logic [23:0] flash_addr,
  output logic        busy,
  output logic [7:0]  rx_byte,
  output logic        mosi,
  input  logic        miso,
  output logic        cs_n,
  output logic        sclk
);

  logic       phase;
  logic       snd_busy;
  logic       snd_busy_q;
  logic       snd_done;
  logic [3:0] rcv_cnt;
  logic       rcv_busy;

  // half-rate phase, sclk runs at clk / 2
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      phase <= 1'b0;
    end else begin
      phase <= !phase;
    end
  end

  // command and address go out on the high phase
  serial_shifter #(
    .payload_t (soc_pkg::flash_cmd_t)
  ) u_shifter (
    .clk     (clk),
    .RESET   (RESET),
    .tick    (phase),
    .load    (load),
    .payload (soc_pkg::flash_cmd_t'({soc_pkg::flash_read_cmd, flash_addr})),
    .sout    (mosi),
    .busy    (snd_busy)
  );

  // falling edge of the send phase
  // covers the one low-phase cycle between send and receive
  assign snd_done = snd_busy_q && !snd_busy;
  assign rcv_busy = (rcv_cnt != '0);

  // receive sequencer and chip select
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      snd_busy_q <= 1'b0;
      rcv_cnt    <= '0;
      cs_n       <= 1'b1;
    end else begin
      snd_busy_q <= snd_busy;
      if (load) begin
        // restart drops any receive in progress
        rcv_cnt <= '0;
        cs_n    <= 1'b0;
      end else if (snd_done) begin
        rcv_cnt <= 4'd8;
      end else if (rcv_busy && phase) begin
        rcv_cnt <= rcv_cnt - 4'd1;
      end else if (!busy) begin
        cs_n <= 1'b1;
      end
    end
  end

  // data byte, msb first, sampled at the end of each high phase
  always_ff @(posedge clk) begin
    if (rcv_busy && phase) begin
      rx_byte <= {rx_byte[6:0], miso};
    end
  end

  assign busy = snd_busy || snd_done || rcv_busy;
  // gap cycle is always a low phase so the clock stays regular
  assign sclk = busy && phase;

endmodule

/* verilog/ledmtx_driver.sv */
// max7219 led matrix sender
// 16-bit frames at clk / 8 with chip select low for the whole frame
module ledmtx_driver (
  input  logic                  clk,
  input  logic                  RESET,
  input  logic                  load,
  input  soc_pkg::ledmtx_word_t data,
  output logic                  busy,
  output logic                  din,
  output logic                  cs,
  output logic                  sclk
);

  logic [soc_pkg::ledmtx_div_w-1:0] div;
  logic                             tick;

  // free-running divider, never stopped or realigned
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      div <= '0;
    end else begin
      div <= div + 1'b1;
    end
  end

  // one tick per divider wrap
  assign tick = (div == '0);

  // shift happens at the end of the tick cycle
  // so din is stable across the whole sclk pulse
  serial_shifter #(
    .payload_t (soc_pkg::ledmtx_word_t)
  ) u_shifter (
    .clk     (clk),
    .RESET   (RESET),
    .tick    (tick),
    .load    (load),
    .payload (data),
    .sout    (din),
    .busy    (busy)
  );

  // frame select, active low
  assign cs   = !busy;
  // clock pulse only in tick cycles of an active frame
  assign sclk = busy && tick;

endmodule

/* verilog/serial_shifter.sv */
// msb-first serial sender shared by the led matrix and flash ports
// payload width comes from the payload type
module serial_shifter #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     RESET,
  // bit-rate enable from the owning driver
  input  logic     tick,
  // one-cycle start, restarts a running transfer
  input  logic     load,
  input  payload_t payload,
  output logic     sout,
  output logic     busy
);

  localparam int width = $bits(payload_t);
  // room for the full count, not just width - 1
  localparam int cnt_w = $clog2(width + 1);

  payload_t         shreg;
  logic [cnt_w-1:0] bit_cnt;

  // shift register and remaining bit count
  // zeros shift in behind the data so sout idles low
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      shreg   <= '0;
      bit_cnt <= '0;
    end else if (load) begin
      shreg   <= payload;
      bit_cnt <= cnt_w'(width);
    end else if (tick && busy) begin
      shreg   <= {shreg[width-2:0], 1'b0};
      bit_cnt <= bit_cnt - 1'b1;
    end
  end

  // msb goes out first
  assign sout = shreg[width-1];

  // bits still pending
  assign busy = (bit_cnt != '0);

endmodule

/* verilog/mem_bus.sv */
// memory bus splitter between the ram page and the io page
// read data returns one cycle after the strobe with an rvalid pulse
module mem_bus (
  input  logic                        clk,
  input  logic                        RESET,
  // processor side
  input  logic [soc_pkg::addr_w-1:0]  addr,
  input  logic [soc_pkg::data_w-1:0]  wdata,
  input  logic [soc_pkg::strb_w-1:0]  wstrb,
  input  logic                        rd,
  output logic [soc_pkg::data_w-1:0]  rdata,
  output logic                        rvalid,
  // ram side
  output logic [soc_pkg::ram_aw-1:0]  ram_addr,
  output logic [soc_pkg::data_w-1:0]  ram_wdata,
  output logic [soc_pkg::strb_w-1:0]  ram_wstrb,
  output logic                        ram_rd,
  input  logic [soc_pkg::data_w-1:0]  ram_rdata,
  // io side
  output logic [soc_pkg::io_aw-1:0]   io_addr,
  output logic [soc_pkg::data_w-1:0]  io_wdata,
  output logic                        io_wr,
  input  logic [soc_pkg::data_w-1:0]  io_rdata
);

  logic                       is_io;
  logic                       io_sel_q;
  logic [soc_pkg::data_w-1:0] io_rdata_q;

  // page select
  assign is_io = addr[soc_pkg::io_page_bit];

  // ram word access, writes masked off on the io page
  assign ram_addr  = addr[soc_pkg::ram_aw+1:2];
  assign ram_wdata = wdata;
  assign ram_wstrb = is_io ? '0 : wstrb;
  assign ram_rd    = rd && !is_io;

  // io word access, same-cycle strobes
  assign io_addr  = addr[soc_pkg::io_aw+1:2];
  assign io_wdata = wdata;
  assign io_wr    = is_io && (wstrb != '0);

  // read return state
  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      rvalid   <= 1'b0;
      io_sel_q <= 1'b0;
    end else begin
      rvalid <= rd;
      if (rd) begin
        io_sel_q <= is_io;
      end
    end
  end

  // io value sampled in the strobe cycle
  always_ff @(posedge clk) begin
    if (rd && is_io) begin
      io_rdata_q <= io_rdata;
    end
  end

  // return mux, ram output is already registered
  assign rdata = io_sel_q ? io_rdata_q : ram_rdata;

endmodule

/* verilog/soc_ram.sv */
// word-organized ram with per-byte write enables
// read data is registered and only updates on a read strobe
module soc_ram (
  input  logic                        clk,
  input  logic [soc_pkg::ram_aw-1:0]  ram_addr,
  input  logic [soc_pkg::data_w-1:0]  ram_wdata,
  input  logic [soc_pkg::strb_w-1:0]  ram_wstrb,
  input  logic                        ram_rd,
  output logic [soc_pkg::data_w-1:0]  ram_rdata
);

  // storage array, contents unknown until written
  logic [soc_pkg::data_w-1:0] mem [soc_pkg::ram_words];

  // byte-lane writes
  // each set mask bit updates its own 8-bit lane
  always_ff @(posedge clk) begin
    for (int lane = 0; lane < soc_pkg::strb_w; lane++) begin
      if (ram_wstrb[lane]) begin
        mem[ram_addr][lane*8 +: 8] <= ram_wdata[lane*8 +: 8];
      end
    end
  end

  // registered read port
  // output holds between reads so the bus mux sees a stable word
  always_ff @(posedge clk) begin
    if (ram_rd) begin
      ram_rdata <= mem[ram_addr];
    end
  end

endmodule

/* verilog/soc_pkg.sv */
// shared widths, register map and payload types for the soc
// memory and peripheral side
package soc_pkg;

  // processor memory bus
  localparam int addr_w = 24;
  localparam int data_w = 32;
  // one mask bit per byte lane
  localparam int strb_w = 4;

  // on-chip ram, 4 kB of 32-bit words
  localparam int ram_words = 1024;
  localparam int ram_aw    = 10;

  // address bit 22 selects the io page
  localparam int io_page_bit = 22;
  // io word address is byte address bits 12 down to 2
  localparam int io_aw = 11;

  // one-hot io register select bits within the io word address
  // led output register
  localparam int leds_bit        = 0;
  // led matrix status, busy in bit 0
  localparam int ledmtx_cntl_bit = 6;
  // led matrix data word, a write starts a send
  localparam int ledmtx_dat_bit  = 7;
  // spi flash address write and data byte read
  localparam int flash_bit       = 8;
  // push buttons
  localparam int buttons_bit     = 10;

  // board io counts
  localparam int n_leds    = 4;
  localparam int n_buttons = 6;

  // led matrix serial clock is clk / 8
  localparam int ledmtx_div_w = 3;

  // spi flash slow read opcode
  localparam logic [7:0] flash_read_cmd = 8'h03;

  // max7219 frame, address nibble plus data byte
  typedef logic [15:0] ledmtx_word_t;
  // flash command byte followed by the 24-bit byte address
  typedef logic [31:0] flash_cmd_t;

endpackage
